/* compile.f */
+incdir+design
design/cache_pkg.sv
design/l1_req_steer.sv
design/l1_cache.sv
design/l2_port_arbiter.sv
design/l2_cache.sv
design/l2_id_cache_top.sv
verification/mem_model.sv
verification/tb_l2_id_cache.sv

/* design/cache_defines.svh */
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// Front-end and memory word format
`define CACHE_ADDR_W   16                    // Byte address
`define CACHE_DATA_W   32                    // One word
`define CACHE_WORD_A_W (`CACHE_ADDR_W - 2)   // Word address

// L1, direct mapped
`define L1_LINE_OFF_W  3    // 8 lines
`define L1_WORD_OFF_W  2    // 4 words per line
`define L1_TAG_W       (`CACHE_WORD_A_W - `L1_LINE_OFF_W - `L1_WORD_OFF_W)

// L2, 2-way
`define L2_LINE_OFF_W  4    // 16 sets
`define L2_WORD_OFF_W  3    // 8 words per line
`define L2_N_WAYS      2
`define L2_TAG_W       (`CACHE_WORD_A_W - `L2_LINE_OFF_W - `L2_WORD_OFF_W)

`define N_L1           2    // 0 is instruction, 1 is data

`define MEM_MIN_WAIT   0    // Memory ready delay bounds, in cycles
`define MEM_MAX_WAIT   3
`endif

/* design/cache_pkg.sv */
`include "cache_defines.svh"

package cache_pkg;

   // Request on every port, all strobes low means read
   typedef struct packed {
      logic [`CACHE_WORD_A_W-1:0] addr;
      logic [`CACHE_DATA_W-1:0]   wdata;
      logic [`CACHE_DATA_W/8-1:0] wstrb;
   } cache_req_t;

   typedef struct packed {
      logic [`CACHE_DATA_W-1:0] rdata;   // Valid with the ready pulse
   } cache_resp_t;

   typedef enum logic [1:0] {
      L1_IDLE, L1_HIT_RESP, L1_FILL, L1_WRITE_THRU
   } l1_state_e;

   typedef enum logic [2:0] {
      L2_IDLE, L2_LOOKUP, L2_FILL, L2_FILL_DONE, L2_WRITE_THRU
   } l2_state_e;

   // Byte-wise merge of a write into a stored word
   function automatic logic [`CACHE_DATA_W-1:0] merge_word(
      input logic [`CACHE_DATA_W-1:0]   old_word,
      input logic [`CACHE_DATA_W-1:0]   new_word,
      input logic [`CACHE_DATA_W/8-1:0] strb
   );
      logic [`CACHE_DATA_W-1:0] res;
      res = old_word;
      for (int b = 0; b < `CACHE_DATA_W/8; b++) begin
         if (strb[b]) res[8*b +: 8] = new_word[8*b +: 8];   // Lane enabled
      end
      return res;
   endfunction

endpackage

/* design/l1_cache.sv */
`include "cache_defines.svh"

module l1_cache import cache_pkg::*; #(
   parameter bit READ_ONLY = 1'b0   // Set on the instruction side
) (
   input  logic        clk,
   input  logic        i_rst,
   // Front side
   input  logic        i_valid,
   input  cache_req_t  i_req,
   output logic        o_ready,
   output cache_resp_t o_rsp,
   // L2 side
   output logic        o_mem_valid,
   output cache_req_t  o_mem_req,
   input  logic        i_mem_ready,
   input  cache_resp_t i_mem_rsp
);

   localparam int N_LINES = 2 ** `L1_LINE_OFF_W;
   localparam int N_WORDS = 2 ** `L1_WORD_OFF_W;

   ////////////////////
   // Storage
   ////////////////////
   logic [`L1_TAG_W-1:0]     tag_mem  [N_LINES];
   logic [N_LINES-1:0]       valid_q;                      // One per line
   logic [`CACHE_DATA_W-1:0] data_mem [N_LINES][N_WORDS];

   // Fields of the word address
   logic [`L1_TAG_W-1:0]      req_tag;
   logic [`L1_LINE_OFF_W-1:0] req_idx;
   logic [`L1_WORD_OFF_W-1:0] req_word;

   l1_state_e                 state_q;
   logic [`L1_WORD_OFF_W-1:0] fill_cnt_q;   // Next word of the line fill
   logic                      hit;
   logic                      is_write;
   logic                      fill_last;

   assign {req_tag, req_idx, req_word} = i_req.addr;

   assign hit       = valid_q[req_idx] && (tag_mem[req_idx] == req_tag);
   assign is_write  = !READ_ONLY && (i_req.wstrb != '0);   // Constant low when read only
   assign fill_last = (state_q == L1_FILL) && i_mem_ready && (&fill_cnt_q);

   ////////////////////
   // Control FSM
   ////////////////////
   always_ff @(posedge clk) begin
      if (i_rst) begin
         state_q    <= L1_IDLE;
         fill_cnt_q <= '0;
         valid_q    <= '0;
      end else begin
         case (state_q)
            L1_IDLE: begin
               if (i_valid) begin
                  if (is_write) begin
                     state_q <= L1_WRITE_THRU;   // No allocate on a miss
                  end else if (hit) begin
                     state_q <= L1_HIT_RESP;
                  end else begin
                     state_q          <= L1_FILL;
                     fill_cnt_q       <= '0;
                     valid_q[req_idx] <= 1'b0;   // Line is rebuilt
                  end
               end
            end
            L1_FILL: begin
               if (i_mem_ready) fill_cnt_q <= fill_cnt_q + 1'b1;
               if (fill_last) begin
                  valid_q[req_idx] <= 1'b1;
                  state_q          <= L1_HIT_RESP;   // Answer from the new line
               end
            end
            L1_HIT_RESP:   state_q <= L1_IDLE;
            L1_WRITE_THRU: if (i_mem_ready) state_q <= L1_IDLE;
            default:       state_q <= L1_IDLE;
         endcase
      end
   end

   // Line data and tags
   always_ff @(posedge clk) begin
      if (state_q == L1_IDLE && i_valid && is_write && hit) begin
         data_mem[req_idx][req_word] <= merge_word(data_mem[req_idx][req_word],
                                                   i_req.wdata, i_req.wstrb);
      end
      if (state_q == L1_FILL && i_mem_ready) begin
         data_mem[req_idx][fill_cnt_q] <= i_mem_rsp.rdata;
      end
      if (fill_last) tag_mem[req_idx] <= req_tag;
   end

   ////////////////////
   // Port outputs
   ////////////////////
   always_comb begin
      o_ready     = 1'b0;
      o_mem_valid = 1'b0;
      o_mem_req   = i_req;   // Writes pass down unchanged
      case (state_q)
         L1_HIT_RESP: o_ready = 1'b1;
         L1_FILL: begin
            o_mem_valid     = 1'b1;
            o_mem_req.addr  = {req_tag, req_idx, fill_cnt_q};   // Word by word
            o_mem_req.wdata = '0;
            o_mem_req.wstrb = '0;
         end
         L1_WRITE_THRU: begin
            o_mem_valid = 1'b1;
            o_ready     = i_mem_ready;   // Done once L2 accepts
         end
         default: ;
      endcase
   end

   assign o_rsp.rdata = data_mem[req_idx][req_word];

   a_ready_pulse: assert property (@(posedge clk) disable iff (i_rst) o_ready |=> !o_ready);

   // L2 request held until accepted
   a_mem_req_hold: assert property (@(posedge clk) disable iff (i_rst)
      o_mem_valid && !i_mem_ready |=> o_mem_valid && $stable(o_mem_req));

endmodule

/* design/l1_req_steer.sv */
`include "cache_defines.svh"

module l1_req_steer import cache_pkg::*; (
   input  logic             clk,
   input  logic             i_rst,
   // Front-end port
   input  logic             i_req_valid,
   input  cache_req_t       i_req,
   input  logic             i_instr,
   output logic             o_req_ready,
   output cache_resp_t      o_rsp,
   // Toward the L1s
   output logic [`N_L1-1:0] o_l1_valid,
   input  logic [`N_L1-1:0] i_l1_ready,
   input  cache_resp_t      i_l1_rsp [`N_L1]
);

   localparam int I_IDX = 0;           // Instruction L1
   localparam int D_IDX = `N_L1 - 1;   // Data L1

   logic to_instr;

   // Instruction L1 is read only, flagged writes go to data side
   assign to_instr = i_instr && (i_req.wstrb == '0);

   always_comb begin
      o_l1_valid = '0;
      o_l1_valid[to_instr ? I_IDX : D_IDX] = i_req_valid;
   end

   // Only one L1 is ever open, so OR the pulses
   assign o_req_ready = |i_l1_ready;

   always_comb begin
      o_rsp = '0;
      for (int k = 0; k < `N_L1; k++) begin
         if (i_l1_ready[k]) o_rsp = i_l1_rsp[k];   // Data of the answering L1
      end
   end

   // Both L1s answering at once means two requests got opened
   a_one_ready: assert property (@(posedge clk) disable iff (i_rst) $onehot0(i_l1_ready));

endmodule

/* design/l2_cache.sv */
`include "cache_defines.svh"

module l2_cache import cache_pkg::*; (
   input  logic        clk,
   input  logic        i_rst,
   // From the arbiter
   input  logic        i_valid,
   input  cache_req_t  i_req,
   output logic        o_ready,
   output cache_resp_t o_rsp,
   // Native memory port
   output logic        o_mem_valid,
   output cache_req_t  o_mem_req,
   input  logic        i_mem_ready,
   input  cache_resp_t i_mem_rsp
);

   localparam int N_SETS  = 2 ** `L2_LINE_OFF_W;
   localparam int N_WORDS = 2 ** `L2_WORD_OFF_W;

   ////////////////////
   // Storage
   ////////////////////
   logic [`L2_TAG_W-1:0]                  tag_mem  [`L2_N_WAYS][N_SETS];
   logic [`L2_N_WAYS-1:0][N_SETS-1:0]     valid_q;
   logic [`CACHE_DATA_W-1:0]              data_mem [`L2_N_WAYS][N_SETS][N_WORDS];
   logic [N_SETS-1:0]                     lru_q;    // Way to evict, one bit per set

   logic [`L2_TAG_W-1:0]      req_tag;
   logic [`L2_LINE_OFF_W-1:0] req_set;
   logic [`L2_WORD_OFF_W-1:0] req_word;

   l2_state_e                 state_q;
   logic [`L2_WORD_OFF_W-1:0] fill_cnt_q;
   logic                      victim_q;   // Way under fill
   logic [`L2_N_WAYS-1:0]     hit;
   logic                      hit_way;
   logic                      rd_way;
   logic                      is_write;
   logic                      fill_last;

   assign {req_tag, req_set, req_word} = i_req.addr;
   assign is_write  = (i_req.wstrb != '0);
   assign fill_last = (state_q == L2_FILL) && i_mem_ready && (&fill_cnt_q);

   // Tag compare on all ways
   always_comb begin
      hit_way = 1'b0;
      for (int w = 0; w < `L2_N_WAYS; w++) begin
         hit[w] = valid_q[w][req_set] && (tag_mem[w][req_set] == req_tag);
         if (hit[w]) hit_way = 1'(w);
      end
   end

   ////////////////////
   // Control FSM
   ////////////////////
   always_ff @(posedge clk) begin
      if (i_rst) begin
         state_q    <= L2_IDLE;
         fill_cnt_q <= '0;
         victim_q   <= 1'b0;
         valid_q    <= '0;
         lru_q      <= '0;
      end else begin
         case (state_q)
            L2_IDLE: if (i_valid) state_q <= L2_LOOKUP;
            L2_LOOKUP: begin
               if (|hit) lru_q[req_set] <= ~hit_way;   // Other way now oldest
               if (is_write) begin
                  state_q <= L2_WRITE_THRU;
               end else if (|hit) begin
                  state_q <= L2_IDLE;
               end else begin
                  state_q                         <= L2_FILL;
                  fill_cnt_q                      <= '0;
                  victim_q                        <= lru_q[req_set];
                  valid_q[lru_q[req_set]][req_set] <= 1'b0;
               end
            end
            L2_FILL: begin
               if (i_mem_ready) fill_cnt_q <= fill_cnt_q + 1'b1;
               if (fill_last) begin
                  valid_q[victim_q][req_set] <= 1'b1;
                  state_q                    <= L2_FILL_DONE;
               end
            end
            L2_FILL_DONE: begin
               lru_q[req_set] <= ~victim_q;
               state_q        <= L2_IDLE;
            end
            L2_WRITE_THRU: if (i_mem_ready) state_q <= L2_IDLE;
            default:       state_q <= L2_IDLE;
         endcase
      end
   end

   // Array writes, write hit or fill word
   always_ff @(posedge clk) begin
      if (state_q == L2_LOOKUP && is_write && (|hit)) begin
         data_mem[hit_way][req_set][req_word] <=
            merge_word(data_mem[hit_way][req_set][req_word], i_req.wdata, i_req.wstrb);
      end
      if (state_q == L2_FILL && i_mem_ready) begin
         data_mem[victim_q][req_set][fill_cnt_q] <= i_mem_rsp.rdata;
      end
      if (fill_last) tag_mem[victim_q][req_set] <= req_tag;
   end

   ////////////////////
   // Port outputs
   ////////////////////
   assign rd_way      = (state_q == L2_LOOKUP) ? hit_way : victim_q;
   assign o_rsp.rdata = data_mem[rd_way][req_set][req_word];

   always_comb begin
      o_ready     = 1'b0;
      o_mem_valid = 1'b0;
      o_mem_req   = i_req;   // Write-through copy
      case (state_q)
         L2_LOOKUP:    o_ready = !is_write && (|hit);
         L2_FILL: begin
            o_mem_valid     = 1'b1;
            o_mem_req.addr  = {req_tag, req_set, fill_cnt_q};
            o_mem_req.wdata = '0;
            o_mem_req.wstrb = '0;
         end
         L2_FILL_DONE: o_ready = 1'b1;   // Served from the victim way
         L2_WRITE_THRU: begin
            o_mem_valid = 1'b1;
            o_ready     = i_mem_ready;
         end
         default: ;
      endcase
   end

   // Fill always replaces the old copy, so a line lives in one way only
   a_single_hit: assert property (@(posedge clk) disable iff (i_rst)
      (state_q == L2_LOOKUP) |-> $onehot0(hit));

endmodule

/* design/l2_id_cache_top.sv */
`include "cache_defines.svh"

module l2_id_cache_top import cache_pkg::*; (
   input  logic        clk,
   input  logic        i_rst,
   // Front-end port
   input  logic        i_req_valid,
   input  cache_req_t  i_req,
   input  logic        i_instr,
   output logic        o_req_ready,
   output cache_resp_t o_rsp,
   // Native memory port
   output logic        o_mem_valid,
   output cache_req_t  o_mem_req,
   input  logic        i_mem_ready,
   input  cache_resp_t i_mem_rsp
);

   logic [`N_L1-1:0] l1_valid;      // Steerer to L1s
   logic [`N_L1-1:0] l1_ready;
   cache_resp_t      l1_rsp [`N_L1];
   logic [`N_L1-1:0] l1_mem_valid;  // L1s to arbiter
   logic [`N_L1-1:0] l1_mem_ready;
   cache_req_t       l1_mem_req [`N_L1];
   cache_resp_t      l1_mem_rsp [`N_L1];
   logic             l2_valid;      // Arbiter to L2
   logic             l2_ready;
   cache_req_t       l2_req;
   cache_resp_t      l2_rsp;

   l1_req_steer steer (
      .clk(clk), .i_rst(i_rst),
      .i_req_valid(i_req_valid), .i_req(i_req), .i_instr(i_instr),
      .o_req_ready(o_req_ready), .o_rsp(o_rsp),
      .o_l1_valid(l1_valid), .i_l1_ready(l1_ready), .i_l1_rsp(l1_rsp)
   );

   // Index 0 instruction, read only
   for (genvar k = 0; k < `N_L1; k++) begin : g_l1
      l1_cache #(.READ_ONLY(k == 0)) l1 (
         .clk(clk), .i_rst(i_rst),
         .i_valid(l1_valid[k]), .i_req(i_req), .o_ready(l1_ready[k]), .o_rsp(l1_rsp[k]),
         .o_mem_valid(l1_mem_valid[k]), .o_mem_req(l1_mem_req[k]),
         .i_mem_ready(l1_mem_ready[k]), .i_mem_rsp(l1_mem_rsp[k])
      );
   end

   l2_port_arbiter arb (
      .clk(clk), .i_rst(i_rst),
      .i_l1_valid(l1_mem_valid), .i_l1_req(l1_mem_req),
      .o_l1_ready(l1_mem_ready), .o_l1_rsp(l1_mem_rsp),
      .o_mem_valid(l2_valid), .o_mem_req(l2_req),
      .i_mem_ready(l2_ready), .i_mem_rsp(l2_rsp)
   );

   l2_cache l2 (
      .clk(clk), .i_rst(i_rst),
      .i_valid(l2_valid), .i_req(l2_req), .o_ready(l2_ready), .o_rsp(l2_rsp),
      .o_mem_valid(o_mem_valid), .o_mem_req(o_mem_req),
      .i_mem_ready(i_mem_ready), .i_mem_rsp(i_mem_rsp)
   );

endmodule

/* design/l2_port_arbiter.sv */
`include "cache_defines.svh"

module l2_port_arbiter import cache_pkg::*; (
   input  logic             clk,
   input  logic             i_rst,
   // L1 side
   input  logic [`N_L1-1:0] i_l1_valid,
   input  cache_req_t       i_l1_req [`N_L1],
   output logic [`N_L1-1:0] o_l1_ready,
   output cache_resp_t      o_l1_rsp [`N_L1],
   // L2 side
   output logic             o_mem_valid,
   output cache_req_t       o_mem_req,
   input  logic             i_mem_ready,
   input  cache_resp_t      i_mem_rsp
);

   localparam int IDX_W = $clog2(`N_L1);

   logic [`N_L1-1:0] grant_q;    // Held until the L2 ready pulse
   logic [`N_L1-1:0] pick;       // Round-robin choice while idle
   logic [`N_L1-1:0] grant;
   logic [IDX_W-1:0] last_q;     // Last L1 served
   logic [IDX_W-1:0] pick_idx;

   // Search starts just after the last winner, closest one wins
   always_comb begin
      pick     = '0;
      pick_idx = last_q;
      for (int k = `N_L1; k > 0; k--) begin
         if (i_l1_valid[(int'(last_q) + k) % `N_L1]) begin
            pick                                = '0;
            pick[(int'(last_q) + k) % `N_L1]    = 1'b1;
            pick_idx = IDX_W'((int'(last_q) + k) % `N_L1);
         end
      end
   end

   assign grant = (grant_q != '0) ? grant_q : pick;   // No extra cycle

   always_ff @(posedge clk) begin
      if (i_rst) begin
         grant_q <= '0;
         last_q  <= '0;
      end else if (i_mem_ready) begin
         grant_q <= '0;                     // Transfer closed
      end else if (grant_q == '0 && pick != '0) begin
         grant_q <= pick;
         last_q  <= pick_idx;
      end
   end

   always_comb begin
      o_mem_req = i_l1_req[0];
      for (int k = 0; k < `N_L1; k++) begin
         if (grant[k]) o_mem_req = i_l1_req[k];
         o_l1_rsp[k] = grant[k] ? i_mem_rsp : '0;   // Only the winner sees data
      end
   end

   assign o_mem_valid = |(grant & i_l1_valid);
   assign o_l1_ready  = grant & {`N_L1{i_mem_ready}};

   a_grant_onehot: assert property (@(posedge clk) disable iff (i_rst) $onehot0(grant_q));

   // A held grant always belongs to an L1 that is still waiting
   a_grant_held: assert property (@(posedge clk) disable iff (i_rst)
      (grant_q != '0) && !i_mem_ready |-> |(grant_q & i_l1_valid));

endmodule

/* verification/mem_model.sv */
`include "cache_defines.svh"

module mem_model import cache_pkg::*; (
   input  logic        clk,
   input  logic        i_rst,
   input  logic        i_valid,
   input  cache_req_t  i_req,
   output logic        o_ready,
   output cache_resp_t o_rsp
);
   timeunit 1ns;
   timeprecision 1ps;

   localparam int N_WORDS = 2 ** `CACHE_WORD_A_W;
   localparam int SPAN    = `MEM_MAX_WAIT - `MEM_MIN_WAIT + 1;

   logic [`CACHE_DATA_W-1:0] mem [N_WORDS];
   logic        busy_q  = 1'b0;   // Request taken, pulse still pending
   int          wait_q  = 0;      // Cycles left before the pulse
   logic        ready_q = 1'b0;
   cache_resp_t rsp_q   = '0;

   assign o_ready = ready_q;
   assign o_rsp   = rsp_q;

   always @(posedge clk) begin
      int   delay;
      logic fire;                 // Transfer happens at this edge
      fire = 1'b0;
      if (i_rst) begin
         busy_q  <= 1'b0;
         ready_q <= 1'b0;
         for (int a = 0; a < N_WORDS; a++) begin
            mem[a] <= 32'(a) ^ 32'h5a5a0000;   // Pattern over the whole word address
         end
      end else begin
         ready_q <= 1'b0;
         if (busy_q) begin
            fire = (wait_q == 0);
            if (!fire) wait_q <= wait_q - 1;
         end else if (i_valid && !ready_q) begin   // Old request still shows in ready cycle
            delay  = `MEM_MIN_WAIT + int'($urandom % SPAN);
            fire   = (delay == 0);
            busy_q <= (delay != 0);
            wait_q <= delay - 1;
         end
         if (fire) begin
            busy_q      <= 1'b0;
            ready_q     <= 1'b1;
            rsp_q.rdata <= mem[i_req.addr];
            for (int b = 0; b < `CACHE_DATA_W/8; b++) begin
               if (i_req.wstrb[b]) mem[i_req.addr][8*b +: 8] <= i_req.wdata[8*b +: 8];
            end
         end
      end
   end

endmodule

/* verification/tb_l2_id_cache.sv */
`include "cache_defines.svh"

module tb_l2_id_cache import cache_pkg::*; ();
   timeunit 1ns;
   timeprecision 1ps;

   localparam int ADDR_W         = `CACHE_WORD_A_W;
   localparam int DATA_W         = `CACHE_DATA_W;
   localparam int STRB_W         = `CACHE_DATA_W / 8;
   localparam int TIMEOUT_CYCLES = 200;
   localparam int FILL_READS     = 2 ** `L2_WORD_OFF_W;   // One L2 line from memory
   localparam logic [ADDR_W-1:0] DATA_BASE = 1 << (ADDR_W - 1);   // Upper half
   localparam logic [ADDR_W-1:0] REPL_BASE = DATA_BASE | 'h800;

   // Extra checks armed for one request
   typedef struct packed {
      logic l1_hit;     // Ready one cycle after valid
      logic no_mem;     // Served without the memory port
      logic mem_fill;   // Exactly one L2 line fill
   } expect_t;

   localparam expect_t PLAIN  = '{l1_hit: 1'b0, no_mem: 1'b0, mem_fill: 1'b0};
   localparam expect_t L1_HIT = '{l1_hit: 1'b1, no_mem: 1'b1, mem_fill: 1'b0};
   localparam expect_t L2_HIT = '{l1_hit: 1'b0, no_mem: 1'b1, mem_fill: 1'b0};
   localparam expect_t FILL   = '{l1_hit: 1'b0, no_mem: 1'b0, mem_fill: 1'b1};

   logic        clk;
   logic        i_rst;
   logic        i_req_valid;
   cache_req_t  i_req;
   logic        i_instr;
   logic        o_req_ready;
   cache_resp_t o_rsp;
   logic        mem_valid;     // Native memory port
   cache_req_t  mem_req;
   logic        mem_ready;
   cache_resp_t mem_rsp;

   expect_t             exp_flags;
   logic [DATA_W-1:0]   exp_rdata;
   int                  mem_rd_cnt;   // Memory traffic of the open request
   int                  mem_wr_cnt;
   logic                mem_rd_hs;
   logic                mem_wr_hs;
   logic [DATA_W-1:0]   shadow [logic [ADDR_W-1:0]];   // Written words only

   l2_id_cache_top DUT (
      .clk(clk), .i_rst(i_rst),
      .i_req_valid(i_req_valid), .i_req(i_req), .i_instr(i_instr),
      .o_req_ready(o_req_ready), .o_rsp(o_rsp),
      .o_mem_valid(mem_valid), .o_mem_req(mem_req),
      .i_mem_ready(mem_ready), .i_mem_rsp(mem_rsp)
   );

   mem_model mem (
      .clk(clk), .i_rst(i_rst),
      .i_valid(mem_valid), .i_req(mem_req), .o_ready(mem_ready), .o_rsp(mem_rsp)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   assign mem_rd_hs = mem_valid && mem_ready && (mem_req.wstrb == '0);
   assign mem_wr_hs = mem_valid && mem_ready && (mem_req.wstrb != '0);

   always @(posedge clk) begin
      if (i_rst || !i_req_valid) begin
         mem_rd_cnt <= 0;
         mem_wr_cnt <= 0;
      end else begin
         mem_rd_cnt <= mem_rd_cnt + int'(mem_rd_hs);
         mem_wr_cnt <= mem_wr_cnt + int'(mem_wr_hs);
      end
   end

   ////////////////////
   // Checks
   ////////////////////
   a_read_data: assert property (@(posedge clk) disable iff (i_rst)
      i_req_valid && (i_req.wstrb == '0) && o_req_ready |-> o_rsp.rdata == exp_rdata)
      else report_error($sformatf("read of word %h returned %h, expected %h",
                        $sampled(i_req.addr), $sampled(o_rsp.rdata), exp_rdata));

   a_wr_match: assert property (@(posedge clk) disable iff (i_rst)
      mem_wr_hs |-> i_req_valid && (mem_req == i_req))
      else report_error($sformatf("memory write %h differs from front-end write %h",
                        $sampled(mem_req), $sampled(i_req)));

   a_wr_once: assert property (@(posedge clk) disable iff (i_rst)
      i_req_valid && (i_req.wstrb != '0) && o_req_ready |-> mem_wr_cnt + int'(mem_wr_hs) == 1)
      else report_error($sformatf("%0d memory writes for one front-end write",
                        $sampled(mem_wr_cnt) + int'($sampled(mem_wr_hs))));

   a_hit_latency: assert property (@(posedge clk) disable iff (i_rst)
      $rose(i_req_valid) && exp_flags.l1_hit |=> o_req_ready)
      else report_error("L1 hit not answered one cycle after valid");

   a_no_mem: assert property (@(posedge clk) disable iff (i_rst)
      i_req_valid && exp_flags.no_mem |-> !mem_valid)
      else report_error($sformatf("memory access on word %h, expected none",
                        $sampled(mem_req.addr)));

   a_fill_reads: assert property (@(posedge clk) disable iff (i_rst)
      i_req_valid && exp_flags.mem_fill && o_req_ready |-> mem_rd_cnt == FILL_READS)
      else report_error($sformatf("%0d memory reads, expected %0d",
                        $sampled(mem_rd_cnt), FILL_READS));

   task automatic report_error(input string what);
      $display("[ERROR] %0t ns %s", $time, what);
      $display("TB FAILED");
      $fatal(1);
   endtask

   function automatic logic [DATA_W-1:0] shadow_read(input logic [ADDR_W-1:0] addr);
      if (shadow.exists(addr)) return shadow[addr];
      return 32'(addr) ^ 32'h5a5a0000;   // Reset-time memory pattern
   endfunction

   function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_word,
         input logic [DATA_W-1:0] new_word, input logic [STRB_W-1:0] strb);
      logic [DATA_W-1:0] res;
      for (int b = 0; b < STRB_W; b++) begin
         res[8*b +: 8] = strb[b] ? new_word[8*b +: 8] : old_word[8*b +: 8];
      end
      return res;
   endfunction

   function automatic logic [STRB_W-1:0] random_strobes();
      return STRB_W'($urandom % ((1 << STRB_W) - 1) + 1);   // Never all zero
   endfunction

   // One front-end transfer, all strobes low is a read
   task automatic run_request(input logic instr, input logic [ADDR_W-1:0] addr,
         input logic [DATA_W-1:0] data, input logic [STRB_W-1:0] strb, input expect_t flags);
      int cycles;
      cycles      = 0;
      exp_rdata   = shadow_read(addr);
      exp_flags   = flags;
      i_instr     = instr;
      i_req.addr  = addr;
      i_req.wdata = data;
      i_req.wstrb = strb;
      i_req_valid = 1'b1;
      do begin
         @(posedge clk);
         #2;
         cycles++;
      end while (!o_req_ready && cycles < TIMEOUT_CYCLES);
      if (!o_req_ready) begin
         $display("request not answered in time");
         $display("TB FAILED");
         $fatal(1);
      end else begin
         @(posedge clk);   // Ready cycle ends here
         #2;
         i_req_valid = 1'b0;
         exp_flags   = PLAIN;
         if (strb != '0) shadow[addr] = merge_bytes(shadow_read(addr), data, strb);
         @(posedge clk);   // Idle cycle between requests
         #2;
      end
   endtask

   ////////////////////
   // Stimulus
   ////////////////////
   initial begin
      int                kind;
      logic [ADDR_W-1:0] offs;
      void'($urandom(32'he93df297));
      i_rst       = 1'b1;
      i_req_valid = 1'b0;
      i_req       = '0;
      i_instr     = 1'b0;
      exp_flags   = PLAIN;
      exp_rdata   = '0;
      repeat (4) @(posedge clk);
      #2;
      i_rst = 1'b0;
      @(posedge clk);
      #2;
      run_request(1'b1, 'h0040, '0, '0, FILL);               // Cold, instruction side
      run_request(1'b0, DATA_BASE | 'h0040, '0, '0, FILL);   // Cold, data side
      run_request(1'b1, 'h0041, '0, '0, L1_HIT);
      run_request(1'b0, DATA_BASE | 'h0043, '0, '0, L1_HIT);
      // Write hit flagged as instruction, lands in data L1
      run_request(1'b1, DATA_BASE | 'h0042, $urandom, random_strobes(), PLAIN);
      run_request(1'b0, DATA_BASE | 'h0042, '0, '0, L1_HIT);
      run_request(1'b0, DATA_BASE | 'h0318, $urandom, random_strobes(), PLAIN);   // No allocate
      run_request(1'b0, DATA_BASE | 'h0318, '0, '0, FILL);
      // Same L2 set and L1 line, 128 words apart
      for (int k = 0; k < 3; k++) run_request(1'b0, REPL_BASE + k * 'h80, '0, '0, FILL);
      run_request(1'b0, REPL_BASE + 'h120, '0, '0, FILL);   // Other set, evicts L1 line
      run_request(1'b0, REPL_BASE + 'h100, '0, '0, L2_HIT); // Most recent line
      run_request(1'b0, REPL_BASE, '0, '0, FILL);           // Evicted as LRU
      run_request(1'b0, REPL_BASE + 'h80, '0, '0, FILL);
      for (int n = 0; n < 300; n++) begin
         kind = int'($urandom % 3);
         offs = ADDR_W'($urandom % 'h200);
         case (kind)
            0:       run_request(1'b1, offs, '0, '0, PLAIN);
            1:       run_request(1'b0, DATA_BASE | offs, '0, '0, PLAIN);
            default: run_request(1'($urandom % 2), DATA_BASE | offs, $urandom,
                                 random_strobes(), PLAIN);
         endcase
      end
      $display("TB PASSED");
      $finish;
   end

endmodule
